//--- Bender.yml
package:
  name: aes_core

sources:
  - target: any(rtl, test)
    files:
      - hw/aes_types_pkg.sv
      - hw/aes_sbox_pkg.sv
      - hw/aes_key_step.sv
      - hw/aes_key_schedule.sv
      - hw/aes_round.sv
      - hw/aes_round_pipe.sv
      - hw/aes_final_round.sv
      - hw/aes_core.sv
  - target: test
    files:
      - bench/aes_core_assert.sv
      - bench/aes_core_tb.sv

//--- aes_core.f
hw/aes_types_pkg.sv
hw/aes_sbox_pkg.sv
hw/aes_key_step.sv
hw/aes_key_schedule.sv
hw/aes_round.sv
hw/aes_round_pipe.sv
hw/aes_final_round.sv
hw/aes_core.sv
bench/aes_core_assert.sv
bench/aes_core_tb.sv

//--- bench/aes_core_assert.sv
////////////////////
// Concurrent checks on the AES core ports
////////////////////
`timescale 1ns/1ps
`default_nettype none

module aes_core_assert
    import aes_types_pkg::*;
(
    input wire clk,
    input wire rst,
    input wire aes_req_s req,
    input wire aes_res_s res
);

    int unsigned calm_cycles = 0;
    int unsigned fail_count = 0;

    // Consecutive cycles with reset low, saturating at the latency
    always @(posedge clk) begin
        if (rst) begin
            calm_cycles <= 0;
        end else if (calm_cycles < CORE_LATENCY) begin
            calm_cycles <= calm_cycles + 1;
        end
    end

    valid_follows_input: assert property (@(posedge clk) disable iff (rst)
        calm_cycles == CORE_LATENCY |-> res.valid == $past(req.valid, CORE_LATENCY))
    else begin
        fail_count++;
        $error("res.valid does not follow req.valid from %0d cycles earlier", CORE_LATENCY);
    end

    text_known: assert property (@(posedge clk) res.valid |-> !$isunknown(res.text))
    else begin
        fail_count++;
        $error("res.text has unknown bits while res.valid is high");
    end

    reset_clears_valid: assert property (@(posedge clk) rst |=> !res.valid)
    else begin
        fail_count++;
        $error("res.valid stayed high after a reset cycle");
    end

endmodule

bind aes_core aes_core_assert u_assert (
    .clk (clk),
    .rst (rst),
    .req (req),
    .res (res)
);

`default_nettype wire

//--- bench/aes_core_tb.sv
////////////////////
// Testbench for the pipelined AES-128 core with a
// reference model, vector table, checks and timeout
////////////////////
`timescale 1ns/1ps
`default_nettype none

module aes_core_tb
    import aes_types_pkg::*, aes_sbox_pkg::*;
();

    typedef struct packed {
        logic valid;
        aes_block_u text;
        aes_block_u key;
        logic known;
        aes_block_u expected;
    } vec_row_s;

    logic clk = 1'b0;
    logic rst;
    aes_req_s req;
    aes_res_s res;

    vec_row_s vectors [$];
    aes_block_u pending [$];
    logic valid_at [int unsigned];
    logic [31:0] rng_state = 32'd63;
    int unsigned cycle = 0;
    int unsigned cycle_limit = 0;
    int unsigned errors = 0;
    int unsigned checks = 0;

    aes_core DUT (
        .clk (clk),
        .rst (rst),
        .req (req),
        .res (res)
    );

    always #10 clk = ~clk;

    ////////////////////
    // Reference model
    ////////////////////
    function automatic aes_block_u model_encrypt(aes_block_u text, aes_block_u key);
        aes_word_t w [44];
        aes_word_t t;
        aes_byte_t rc;
        aes_byte_t s [16];
        aes_byte_t u [16];
        aes_block_u out;
        rc = 8'h01;
        for (int i = 0; i < 4; i++) begin
            w[i] = key.cols[i];
        end
        for (int i = 4; i < 44; i++) begin
            t = w[i-1];
            if (i % 4 == 0) begin
                t = {t[23:0], t[31:24]};
                t = {sbox_byte(t[31:24]), sbox_byte(t[23:16]),
                     sbox_byte(t[15:8]), sbox_byte(t[7:0])};
                t[31:24] = t[31:24] ^ rc;
                rc = xtime(rc);
            end
            w[i] = w[i-4] ^ t;
        end
        for (int i = 0; i < 16; i++) begin
            s[i] = text.bytes[i] ^ w[i/4][31 - 8*(i%4) -: 8];
        end
        for (int rnd = 1; rnd <= NUM_ROUNDS; rnd++) begin
            // Substitute and shift rows in one pass
            for (int i = 0; i < 16; i++) begin
                u[i] = sbox_byte(s[4*((i/4 + i%4) % 4) + i%4]);
            end
            for (int c = 0; c < 4; c++) begin
                for (int r = 0; r < 4; r++) begin
                    if (rnd < NUM_ROUNDS) begin
                        s[4*c + r] = xtime(u[4*c + r]) ^ xtime(u[4*c + (r+1)%4])
                            ^ u[4*c + (r+1)%4] ^ u[4*c + (r+2)%4] ^ u[4*c + (r+3)%4];
                    end else begin
                        s[4*c + r] = u[4*c + r];
                    end
                    s[4*c + r] = s[4*c + r] ^ w[4*rnd + c][31 - 8*r -: 8];
                end
            end
        end
        for (int i = 0; i < 16; i++) begin
            out.bytes[i] = s[i];
        end
        return out;
    endfunction

    ////////////////////
    // Stimulus helpers
    ////////////////////
    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic aes_block_u random_block();
        aes_block_u blk;
        for (int i = 0; i < 4; i++) begin
            rng_state = xorshift32(rng_state);
            blk.cols[i] = rng_state;
        end
        return blk;
    endfunction

    task automatic add_row(input logic valid, input aes_block_u text, input aes_block_u key,
                           input logic known, input aes_block_u expected);
        vec_row_s row;
        row.valid = valid;
        row.text = text;
        row.key = key;
        row.known = known;
        row.expected = expected;
        vectors.push_back(row);
    endtask

    task automatic check_block(input string name, input aes_block_u actual,
                               input aes_block_u expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_valid(input string name, input logic actual, input logic expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t: %s is %b, expected %b", $time, name, actual, expected);
        end
    endtask

    // Cycle count and run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle_limit != 0 && cycle >= cycle_limit) begin
            $display("Timeout: results still missing after %0d cycles", cycle);
            $display("Something failed");
            $finish;
        end
    end

    ////////////////////
    // Output monitor
    ////////////////////
    // Expected valid in every cycle and texts in order
    always @(negedge clk) begin : monitor
        logic exp_valid;
        exp_valid = valid_at.exists(cycle) ? valid_at[cycle] : 1'b0;
        check_valid("res.valid", res.valid, exp_valid);
        if (res.valid === 1'b1) begin
            if (pending.size() == 0) begin
                errors++;
                $display("A valid result came out at %0t with no block pending", $time);
            end else begin
                check_block("res.text", res.text, pending.pop_front());
            end
        end
    end

    initial begin : main
        vec_row_s row;
        aes_block_u expected;
        req = '0;
        rst = 1'b1;

        // FIPS-197 C.1 and B
        add_row(1'b1, 128'h00112233445566778899aabbccddeeff,
                128'h000102030405060708090a0b0c0d0e0f, 1'b1,
                128'h69c4e0d86a7b0430d8cdb78070b4c55a);
        add_row(1'b1, 128'h3243f6a8885a308d313198a2e0370734,
                128'h2b7e151628aed2a6abf7158809cf4f3c, 1'b1,
                128'h3925841d02dc09fbdc118597196a0b32);
        foreach (vectors[i]) begin
            check_block("model output", model_encrypt(vectors[i].text, vectors[i].key),
                        vectors[i].expected);
        end
        for (int i = 0; i < 32; i++) begin
            add_row(1'b1, random_block(), random_block(), 1'b0, '0);
        end
        // Gaps every third row
        for (int i = 0; i < 16; i++) begin
            add_row(i % 3 != 1, random_block(), random_block(), 1'b0, '0);
        end
        cycle_limit = vectors.size() + CORE_LATENCY + 50;

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        foreach (vectors[i]) begin
            @(posedge clk);
            #1;
            row = vectors[i];
            req.valid = row.valid;
            req.text = row.text;
            req.key = row.key;
            valid_at[cycle + CORE_LATENCY] = row.valid;
            if (row.valid) begin
                expected = row.known ? row.expected : model_encrypt(row.text, row.key);
                pending.push_back(expected);
            end
        end
        @(posedge clk);
        #1;
        req.valid = 1'b0;

        while (pending.size() != 0) begin
            @(posedge clk);
        end
        repeat (CORE_LATENCY) @(posedge clk);

        errors = errors + DUT.u_assert.fail_count;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/aes_core.sv
////////////////////
// Pipelined AES-128 encryption core top level
////////////////////
`timescale 1ns/1ps
`default_nettype none

module aes_core
    import aes_types_pkg::*;
(
    input  wire clk,
    input  wire rst,
    input  wire aes_req_s req,
    output aes_res_s res
);

    aes_block_u round_keys [NUM_ROUNDS];
    aes_block_u mid_state;
    logic mid_valid;

    // Each round key is tapped on the cycle its round consumes it
    aes_key_schedule u_key_schedule (
        .clk        (clk),
        .key        (req.key),
        .round_keys (round_keys)
    );

    aes_round_pipe u_round_pipe (
        .clk        (clk),
        .rst        (rst),
        .text       (req.text),
        .key        (req.key),
        .in_valid   (req.valid),
        .round_keys (round_keys[0:NUM_ROUNDS-2]),
        .mid_state  (mid_state),
        .mid_valid  (mid_valid)
    );

    aes_final_round u_final_round (
        .clk         (clk),
        .rst         (rst),
        .state_in    (mid_state),
        .state_valid (mid_valid),
        .round_key   (round_keys[NUM_ROUNDS-1]),
        .res         (res)
    );

endmodule

`default_nettype wire

//--- hw/aes_final_round.sv
////////////////////
// Final round without column mix, drives the result
////////////////////
`timescale 1ns/1ps
`default_nettype none

module aes_final_round
    import aes_types_pkg::*, aes_sbox_pkg::*;
(
    input  wire clk,
    input  wire rst,
    input  wire aes_block_u state_in,
    input  wire state_valid,
    input  wire aes_block_u round_key,
    output aes_res_s res
);

    aes_byte_t sb_q [BLOCK_BITS/8];
    aes_block_u shifted;
    logic valid_q;

    // SubBytes
    always_ff @(posedge clk) begin
        for (int i = 0; i < BLOCK_BITS / 8; i++) begin
            sb_q[i] <= sbox_byte(state_in.bytes[i]);
        end
    end

    // ShiftRows through the byte view, then the last round key
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                shifted.bytes[4*c + r] = sb_q[4*((c + r) % 4) + r] ^ round_key.bytes[4*c + r];
            end
        end
    end

    ////////////////////
    // Result register
    ////////////////////
    always_ff @(posedge clk) begin
        res.text <= shifted;
        if (rst) begin
            valid_q <= 1'b0;
            res.valid <= 1'b0;
        end else begin
            valid_q <= state_valid;
            res.valid <= valid_q;
        end
    end

endmodule

`default_nettype wire

//--- hw/aes_key_schedule.sv
////////////////////
// Key register and the ten chained expansion steps
////////////////////
`timescale 1ns/1ps
`default_nettype none

module aes_key_schedule
    import aes_types_pkg::*;
(
    input  wire clk,
    input  wire aes_block_u key,
    output aes_block_u round_keys [NUM_ROUNDS]
);

    aes_block_u key_q;
    aes_block_u step_in [NUM_ROUNDS];
    // Last entry has no consumer
    aes_block_u step_out [NUM_ROUNDS];

    // Aligned with the whitening register in the round pipe
    always_ff @(posedge clk) begin
        key_q <= key;
    end

    assign step_in[0] = key_q;

    ////////////////////
    // Step chain
    ////////////////////
    for (genvar i = 0; i < NUM_ROUNDS; i++) begin : g_step
        if (i > 0) begin : g_link
            assign step_in[i] = step_out[i-1];
        end

        // Round key i+1 leaves early, the chained key one cycle after
        aes_key_step u_key_step (
            .clk       (clk),
            .key_in    (step_in[i]),
            .rcon      (ROUND_CONST[i]),
            .round_key (round_keys[i]),
            .key_out   (step_out[i])
        );
    end

endmodule

`default_nettype wire

//--- hw/aes_key_step.sv
////////////////////
// One round-key expansion stage, two cycles deep
////////////////////
`timescale 1ns/1ps
`default_nettype none

module aes_key_step
    import aes_types_pkg::*, aes_sbox_pkg::*;
(
    input  wire clk,
    input  wire aes_block_u key_in,
    input  wire aes_byte_t rcon,
    output aes_block_u round_key,
    output aes_block_u key_out
);

    aes_block_u running;
    aes_block_u running_q;
    aes_word_t rot_word;
    aes_word_t sub_q;

    ////////////////////
    // Stage 1
    ////////////////////
    // Round constant into the top byte, then prefix XOR across the words
    always_comb begin
        running.cols[0] = key_in.cols[0] ^ {rcon, 24'h000000};
        for (int j = 1; j < BLOCK_BITS / WORD_BITS; j++) begin
            running.cols[j] = running.cols[j-1] ^ key_in.cols[j];
        end
    end

    // RotWord of the last column
    assign rot_word = {key_in.cols[3][23:0], key_in.cols[3][31:24]};

    always_ff @(posedge clk) begin
        running_q <= running;
        sub_q <= sub_word(rot_word);
    end

    ////////////////////
    // Stage 2
    ////////////////////
    always_comb begin
        for (int j = 0; j < BLOCK_BITS / WORD_BITS; j++) begin
            round_key.cols[j] = running_q.cols[j] ^ sub_q;
        end
    end

    // Same key one cycle later for the next step
    always_ff @(posedge clk) begin
        key_out <= round_key;
    end

endmodule

`default_nettype wire

//--- hw/aes_round.sv
////////////////////
// One middle AES round over two register stages
////////////////////
`timescale 1ns/1ps
`default_nettype none

module aes_round
    import aes_types_pkg::*, aes_sbox_pkg::*;
(
    input  wire clk,
    input  wire aes_block_u state_in,
    input  wire aes_block_u round_key,
    output aes_block_u state_out
);

    aes_byte_t sb_q [BLOCK_BITS/8];
    aes_byte_t xt_q [BLOCK_BITS/8];
    aes_word_t lookup [BLOCK_BITS/8];
    aes_block_u mix;

    ////////////////////
    // Stage 1
    ////////////////////
    // S-box and S-box times x for every byte
    always_ff @(posedge clk) begin
        for (int i = 0; i < BLOCK_BITS / 8; i++) begin
            sb_q[i] <= sbox_byte(state_in.bytes[i]);
            xt_q[i] <= xtime(sbox_byte(state_in.bytes[i]));
        end
    end

    // Row 0 word is {2s, s, s, 3s}, row r rotates it right by r bytes
    for (genvar i = 0; i < BLOCK_BITS / 8; i++) begin : g_lookup
        logic [2*WORD_BITS-1:0] twice;

        assign twice = {2{xt_q[i], sb_q[i], sb_q[i], xt_q[i] ^ sb_q[i]}};
        assign lookup[i] = twice[8*(i%4) +: WORD_BITS];
    end

    ////////////////////
    // Stage 2
    ////////////////////
    // Output column c collects row r from column c+r (ShiftRows)
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            mix.cols[c] = round_key.cols[c];
            for (int r = 0; r < 4; r++) begin
                mix.cols[c] = mix.cols[c] ^ lookup[4*((c + r) % 4) + r];
            end
        end
    end

    always_ff @(posedge clk) begin
        state_out <= mix;
    end

endmodule

`default_nettype wire

//--- hw/aes_round_pipe.sv
////////////////////
// Key whitening, nine middle rounds, valid shift register
////////////////////
`timescale 1ns/1ps
`default_nettype none

module aes_round_pipe
    import aes_types_pkg::*;
(
    input  wire clk,
    input  wire rst,
    input  wire aes_block_u text,
    input  wire aes_block_u key,
    input  wire in_valid,
    input  wire aes_block_u round_keys [NUM_ROUNDS-1],
    output aes_block_u mid_state,
    output logic mid_valid
);

    aes_block_u white_q;
    aes_block_u round_in [NUM_ROUNDS-1];
    aes_block_u round_out [NUM_ROUNDS-1];
    // One bit per cycle from whitening to the end of round 9
    logic [(NUM_ROUNDS-1)*ROUND_CYCLES:0] valid_q;

    always_ff @(posedge clk) begin
        white_q <= text ^ key;
    end

    assign round_in[0] = white_q;

    ////////////////////
    // Round chain
    ////////////////////
    for (genvar i = 0; i < NUM_ROUNDS - 1; i++) begin : g_round
        if (i > 0) begin : g_link
            assign round_in[i] = round_out[i-1];
        end

        aes_round u_round (
            .clk       (clk),
            .state_in  (round_in[i]),
            .round_key (round_keys[i]),
            .state_out (round_out[i])
        );
    end

    assign mid_state = round_out[NUM_ROUNDS-2];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[(NUM_ROUNDS-1)*ROUND_CYCLES-1:0], in_valid};
        end
    end

    assign mid_valid = valid_q[(NUM_ROUNDS-1)*ROUND_CYCLES];

endmodule

`default_nettype wire

//--- hw/aes_sbox_pkg.sv
////////////////////
// Forward S-box table and the byte and word
// field functions built on it
////////////////////
`default_nettype none

package aes_sbox_pkg;

    import aes_types_pkg::*;

    ////////////////////
    // S-box, entry 0 in the top byte
    ////////////////////
    localparam aes_byte_t [0:255] SBOX = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    ////////////////////
    // Field functions
    ////////////////////
    function automatic aes_byte_t sbox_byte(aes_byte_t b);
        return SBOX[b];
    endfunction

    // Multiply by x modulo x^8 + x^4 + x^3 + x + 1
    function automatic aes_byte_t xtime(aes_byte_t b);
        aes_byte_t shifted;
        shifted = {b[6:0], 1'b0};
        if (b[7]) begin
            shifted = shifted ^ 8'h1b;
        end
        return shifted;
    endfunction

    // Substitute the four bytes of a word independently
    function automatic aes_word_t sub_word(aes_word_t w);
        aes_word_t result;
        for (int i = 0; i < WORD_BITS / 8; i++) begin
            result[8*i +: 8] = sbox_byte(w[8*i +: 8]);
        end
        return result;
    endfunction

endpackage

`default_nettype wire

//--- hw/aes_types_pkg.sv
////////////////////
// AES-128 widths and pipeline latency, block union,
// request and result bundles, round constants
////////////////////
`default_nettype none

package aes_types_pkg;

    ////////////////////
    // Widths and latency
    ////////////////////
    localparam int BLOCK_BITS = 128;
    localparam int WORD_BITS = 32;
    localparam int NUM_ROUNDS = 10;
    localparam int ROUND_CYCLES = 2;

    // Whitening register, then two cycles for each round
    localparam int CORE_LATENCY = 1 + NUM_ROUNDS * ROUND_CYCLES;

    typedef logic [WORD_BITS-1:0] aes_word_t;
    typedef logic [7:0] aes_byte_t;

    ////////////////////
    // Block views
    ////////////////////
    // Column 0 and byte 0 sit in the top bits, as in FIPS-197 input order
    typedef union packed {
        aes_word_t [0:BLOCK_BITS/WORD_BITS-1] cols;
        aes_byte_t [0:BLOCK_BITS/8-1] bytes;
    } aes_block_u;

    // Core input, one block and its own key
    typedef struct packed {
        logic valid;
        aes_block_u text;
        aes_block_u key;
    } aes_req_s;

    // Core output
    typedef struct packed {
        logic valid;
        aes_block_u text;
    } aes_res_s;

    ////////////////////
    // Key expansion
    ////////////////////
    localparam aes_byte_t ROUND_CONST [NUM_ROUNDS] = '{
        8'h01,
        8'h02,
        8'h04,
        8'h08,
        8'h10,
        8'h20,
        8'h40,
        8'h80,
        8'h1b,
        8'h36
    };

endpackage

`default_nettype wire
